//--- sdram_subsystem.f
verilog/sdram_pkg.sv
verilog/sdram_request_queue.sv
verilog/sdram_bank_tracker.sv
verilog/sdram_command_sequencer.sv
verilog/sdram_subsystem.sv
test/sdram_chip_model.sv
test/sdram_checker.sv
test/tb_sdram_subsystem.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the SDRAM subsystem testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f sdram_subsystem.f --top-module tb_sdram_subsystem \
	-Mdir obj_dir -o sim_sdram

./obj_dir/sim_sdram | tee sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

//--- test/tb_sdram_subsystem.sv
// Testbench for the SDRAM controller subsystem.
// Credit-respecting host stimulus, chip model on the pins, a checker
// module and a watchdog.

`timescale 1ns/10ps
`default_nettype none

module tb_sdram_subsystem;

	localparam int QUEUE_DEPTH = 4;
	localparam int STARTUP_CYCLES = 40;
	localparam int MODE_WAIT = 2;
	localparam int REFRESH_INTERVAL = 60;
	localparam int LONGEST_ACCESS = 16;	// Conflict read plus precharge-all, with margin.
	localparam int POOL_SIZE = 16;
	localparam int RANDOM_OPS = 300;
	localparam int TOTAL_REQUESTS = 12 + 3 * POOL_SIZE + RANDOM_OPS + QUEUE_DEPTH;
	localparam int WATCHDOG_CYCLES = STARTUP_CYCLES + 200 + TOTAL_REQUESTS * 30;

	logic clock;
	logic reset;
	logic req;
	logic rw;
	logic [31:0] address;
	logic [31:0] wdata;
	logic [3:0] wmask;
	wire credit;
	wire [31:0] rdata;
	wire rvalid;
	wire sdram_cke;
	wire sdram_cs_n;
	wire sdram_ras_n;
	wire sdram_cas_n;
	wire sdram_we_n;
	wire [1:0] sdram_dqm;
	wire [1:0] sdram_ba;
	wire [12:0] sdram_addr;
	wire [15:0] sdram_wdata;
	wire sdram_data_oe;
	wire [15:0] sdram_rdata;
	int data_errors;
	int protocol_errors;
	int pending_reads;

	integer seed = 32'hb17a3436;
	int sent;
	int returned;
	logic [31:0] pool [POOL_SIZE];

	sdram_subsystem #(
		.QUEUE_DEPTH(QUEUE_DEPTH),
		.STARTUP_CYCLES(STARTUP_CYCLES),
		.MODE_WAIT(MODE_WAIT),
		.REFRESH_INTERVAL(REFRESH_INTERVAL)
	) DUT (
		.i_clock(clock), .i_reset(reset), .i_req(req), .i_rw(rw),
		.i_address(address), .i_wdata(wdata), .i_wmask(wmask),
		.o_credit(credit), .o_rdata(rdata), .o_rvalid(rvalid),
		.o_sdram_cke(sdram_cke), .o_sdram_cs_n(sdram_cs_n),
		.o_sdram_ras_n(sdram_ras_n), .o_sdram_cas_n(sdram_cas_n),
		.o_sdram_we_n(sdram_we_n), .o_sdram_dqm(sdram_dqm), .o_sdram_ba(sdram_ba),
		.o_sdram_addr(sdram_addr), .o_sdram_wdata(sdram_wdata),
		.o_sdram_data_oe(sdram_data_oe), .i_sdram_rdata(sdram_rdata)
	);

	sdram_chip_model u_chip (
		.i_clock(clock), .i_cke(sdram_cke), .i_cs_n(sdram_cs_n),
		.i_ras_n(sdram_ras_n), .i_cas_n(sdram_cas_n), .i_we_n(sdram_we_n),
		.i_dqm(sdram_dqm), .i_ba(sdram_ba), .i_addr(sdram_addr),
		.i_wdata(sdram_wdata), .o_rdata(sdram_rdata)
	);

	sdram_checker #(
		.REFRESH_INTERVAL(REFRESH_INTERVAL),
		.LONGEST_ACCESS(LONGEST_ACCESS)
	) u_check (
		.i_clock(clock), .i_reset(reset), .i_req(req), .i_rw(rw),
		.i_address(address), .i_wdata(wdata), .i_wmask(wmask), .i_credit(credit),
		.i_rdata(rdata), .i_rvalid(rvalid), .i_cs_n(sdram_cs_n),
		.i_ras_n(sdram_ras_n), .i_cas_n(sdram_cas_n), .i_we_n(sdram_we_n),
		.i_addr(sdram_addr), .i_data_oe(sdram_data_oe),
		.o_data_errors(data_errors), .o_protocol_errors(protocol_errors),
		.o_pending_reads(pending_reads)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// Host credit counter, one per pulse seen at an edge.
	always @(posedge clock) begin
		if (reset)
			returned <= 0;
		else if (credit)
			returned <= returned + 1;
	end

	function automatic int pick(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic logic [31:0] make_address(input int bank, input int row, input int col);
		return {7'd0, 13'(row), 2'(bank), 8'(col), 2'b00};
	endfunction

	// Holds off while every credit is spent.
	task automatic send_request(input logic write, input logic [31:0] addr,
		input logic [31:0] data, input logic [3:0] mask);
		@(posedge clock);
		while (sent - returned >= QUEUE_DEPTH) begin
			req <= 1'b0;
			@(posedge clock);
		end
		req <= 1'b1;
		rw <= write;
		address <= addr;
		wdata <= data;
		wmask <= mask;
		sent++;
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) begin
			@(posedge clock);
			req <= 1'b0;
		end
	endtask

	task automatic drain;
		idle(1);
		while (returned != sent || pending_reads != 0)
			@(posedge clock);
	endtask

	// ============================================================
	// Stimulus.
	// ============================================================
	initial begin
		reset = 1'b1;
		req = 1'b0;
		rw = 1'b0;
		address = '0;
		wdata = '0;
		wmask = '0;
		sent = 0;
		repeat (4) @(posedge clock);
		reset <= 1'b0;

		// Queued during power-up, served only after mode set.
		send_request(1'b1, make_address(2, 1, 4), 32'h1234_5678, 4'hf);
		send_request(1'b0, make_address(2, 1, 4), '0, '0);

		// Empty, hit and conflict paths in bank 1.
		send_request(1'b1, make_address(1, 100, 7), 32'hcafe_0001, 4'hf);
		send_request(1'b0, make_address(1, 100, 7), '0, '0);
		send_request(1'b1, make_address(1, 200, 7), 32'hbeef_0002, 4'hf);
		send_request(1'b0, make_address(1, 200, 7), '0, '0);
		send_request(1'b0, make_address(1, 100, 7), '0, '0);
		send_request(1'b1, make_address(1, 100, 8), 32'h0bad_f00d, 4'hf);
		send_request(1'b0, make_address(1, 100, 8), '0, '0);
		send_request(1'b1, make_address(3, 5, 0), 32'h5a5a_a5a5, 4'hf);
		send_request(1'b0, make_address(3, 5, 0), '0, '0);
		drain();

		// Partial writes merge into full words.
		for (int i = 0; i < POOL_SIZE; i++) begin
			pool[i] = make_address(pick(4), pick(4), pick(256));
			send_request(1'b1, pool[i], 32'($random(seed)), 4'hf);
		end
		for (int i = 0; i < POOL_SIZE; i++)
			send_request(1'b1, pool[i], 32'($random(seed)), 4'(pick(16)));
		for (int i = 0; i < POOL_SIZE; i++)
			send_request(1'b0, pool[i], '0, '0);
		drain();

		// Random traffic across many refresh intervals.
		for (int i = 0; i < RANDOM_OPS; i++) begin
			case (pick(3))
				0: send_request(1'b0, pool[pick(POOL_SIZE)], '0, '0);
				1: send_request(1'b1, pool[pick(POOL_SIZE)], 32'($random(seed)), 4'hf);
				default: send_request(1'b1, pool[pick(POOL_SIZE)], 32'($random(seed)),
					4'(pick(16)));
			endcase
			idle(pick(4));
		end
		drain();

		// A full queue of reads sent back to back.
		for (int i = 0; i < QUEUE_DEPTH; i++)
			send_request(1'b0, pool[i], '0, '0);
		drain();
		idle(10);

		$display("Checks done: %0d data errors, %0d protocol errors",
			data_errors, protocol_errors);
		if (data_errors == 0 && protocol_errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("ERROR: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Checks done: %0d data errors, %0d protocol errors",
			data_errors, protocol_errors);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- test/sdram_checker.sv
// Testbench checker for the SDRAM subsystem.
// Keeps a shadow memory of host writes, compares read data in order and
// watches the command pins, read latency, refresh spacing and credits.

`timescale 1ns/10ps
`default_nettype none

module sdram_checker #(
	parameter int REFRESH_INTERVAL = 60,
	parameter int LONGEST_ACCESS = 16
)(
	input wire i_clock,
	input wire i_reset,
	input wire i_req,
	input wire i_rw,
	input wire [31:0] i_address,
	input wire [31:0] i_wdata,
	input wire [3:0] i_wmask,
	input wire i_credit,
	input wire [31:0] i_rdata,
	input wire i_rvalid,
	input wire i_cs_n,
	input wire i_ras_n,
	input wire i_cas_n,
	input wire i_we_n,
	input wire [12:0] i_addr,
	input wire i_data_oe,
	output int o_data_errors,
	output int o_protocol_errors,
	output int o_pending_reads
);
	localparam logic [3:0] NOP = 4'b0111;
	localparam logic [3:0] PRECHARGE = 4'b0010;
	localparam logic [3:0] SET_MODE = 4'b0000;
	localparam logic [3:0] REFRESH = 4'b0001;
	localparam logic [3:0] READ = 4'b0101;
	localparam logic [3:0] WRITE = 4'b0100;
	localparam logic [12:0] EXPECTED_MODE = 13'h021;	// CAS 2, sequential, burst 2.
	localparam int READ_LATENCY = 5;	// CAS latency plus three.

	logic [31:0] shadow [logic [22:0]];
	logic [31:0] expected_q [$];
	int read_cycle_q [$];
	logic [3:0] cmd;
	logic [31:0] expected;
	logic write_beat;
	logic in_order;
	int cycle;
	int in_flight;
	int unserved_credits;
	int startup_step;
	int since_refresh;
	int issued;

	assign cmd = {i_cs_n, i_ras_n, i_cas_n, i_we_n};

	// Expected word after a masked write: mask bit set takes the new byte.
	function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
		input logic [31:0] new_word, input logic [3:0] mask);
		logic [31:0] result;
		result = old_word;
		for (int i = 0; i < 4; i++)
			if (mask[i])
				result[8*i +: 8] = new_word[8*i +: 8];
		return result;
	endfunction

	task automatic protocol_error(input string what);
		o_protocol_errors++;
		$display("ERROR at %0t: %s", $time, what);
	endtask

	always @(posedge i_clock) begin
		if (i_reset) begin
			o_data_errors = 0;
			o_protocol_errors = 0;
			o_pending_reads = 0;
			expected_q.delete();
			read_cycle_q.delete();
			cycle = 0;
			in_flight = 0;
			unserved_credits = 0;
			startup_step = 0;
			since_refresh = 0;
			write_beat = 1'b0;
		end else begin
			cycle++;

			// ============================================================
			// Host side: credits and shadow memory.
			// ============================================================
			if (i_credit && in_flight == 0)
				protocol_error("credit returned with no request in the queue");
			if (i_req) begin
				expected = shadow.exists(i_address[24:2]) ? shadow[i_address[24:2]] : '0;
				if (i_rw)
					shadow[i_address[24:2]] = merge_bytes(expected, i_wdata, i_wmask);
				else
					expected_q.push_back(expected);
			end
			in_flight = in_flight + (i_req ? 1 : 0) - (i_credit ? 1 : 0);
			if (i_credit)
				unserved_credits++;

			// ============================================================
			// Command pins.
			// ============================================================
			if (startup_step < 4) begin
				if (cmd != NOP) begin
					case (startup_step)
						0: in_order = (cmd == PRECHARGE) && i_addr[10];
						1, 2: in_order = (cmd == REFRESH);
						default: in_order = (cmd == SET_MODE) && (i_addr == EXPECTED_MODE);
					endcase
					if (!in_order)
						protocol_error($sformatf("command %b out of order at power-up", cmd));
					startup_step++;
				end
			end else begin
				since_refresh++;
				if (cmd == REFRESH)
					since_refresh = 0;
				else if (since_refresh == REFRESH_INTERVAL + LONGEST_ACCESS + 1)
					protocol_error("refresh overdue");
			end
			if (cmd == READ)
				read_cycle_q.push_back(cycle);

			// Each access on the pins follows the credit of its pop.
			if (cmd == READ || cmd == WRITE) begin
				if (unserved_credits == 0)
					protocol_error("READ or WRITE on the pins without a credit returned for it");
				else
					unserved_credits--;
			end
			if ((cmd == WRITE || write_beat) && !i_data_oe)
				protocol_error("write beat without data output enable");
			write_beat = (cmd == WRITE);

			// Read returns, in request order.
			if (i_rvalid) begin
				if (expected_q.size() == 0) begin
					protocol_error("o_rvalid with no read outstanding");
				end else begin
					expected = expected_q.pop_front();
					if (i_rdata !== expected) begin
						o_data_errors++;
						$display("FAILED at %0t: o_rdata expected %h actual %h",
							$time, expected, i_rdata);
					end
				end
				if (read_cycle_q.size() == 0) begin
					protocol_error("o_rvalid without a READ command on the pins");
				end else begin
					issued = read_cycle_q.pop_front();
					if (cycle - issued != READ_LATENCY) begin
						o_protocol_errors++;
						$display("FAILED at %0t: o_rvalid latency expected %0d actual %0d",
							$time, READ_LATENCY, cycle - issued);
					end
				end
			end
			o_pending_reads = expected_q.size();
		end
	end

endmodule

`default_nettype wire

//--- test/sdram_chip_model.sv
// Behavioural SDR SDRAM for simulation.
// Fixed CAS 2 and burst 2, DQM byte masking, sparse cell storage.

`timescale 1ns/10ps
`default_nettype none

module sdram_chip_model (
	input wire i_clock,
	input wire i_cke,
	input wire i_cs_n,
	input wire i_ras_n,
	input wire i_cas_n,
	input wire i_we_n,
	input wire [1:0] i_dqm,
	input wire [1:0] i_ba,
	input wire [12:0] i_addr,
	input wire [15:0] i_wdata,
	output logic [15:0] o_rdata
);
	localparam logic [3:0] ACTIVATE = 4'b0011;
	localparam logic [3:0] READ = 4'b0101;
	localparam logic [3:0] WRITE = 4'b0100;

	logic [15:0] mem [logic [23:0]];	// Key is bank, row, chip column.
	logic [12:0] open_row [4];
	logic [23:0] read_key;
	logic [23:0] write_key;
	logic read_beat_0;
	logic read_beat_1;
	logic write_beat_1;

	// Unwritten cells read back a pattern built from the full key.
	function automatic logic [15:0] fetch(input logic [23:0] key);
		if (mem.exists(key))
			return mem[key];
		return key[15:0] ^ {key[23:16], key[23:16]};
	endfunction

	task automatic store(input logic [23:0] key, input logic [15:0] data, input logic [1:0] dqm);
		logic [15:0] word;
		word = fetch(key);
		if (!dqm[0])
			word[7:0] = data[7:0];
		if (!dqm[1])
			word[15:8] = data[15:8];
		mem[key] = word;
	endtask

	always @(posedge i_clock) begin
		read_beat_0 <= 1'b0;
		read_beat_1 <= read_beat_0;
		write_beat_1 <= 1'b0;
		if (read_beat_0)
			o_rdata <= fetch(read_key);	// Sampled two edges after READ.
		if (read_beat_1)
			o_rdata <= fetch(read_key + 24'd1);
		if (write_beat_1)
			store(write_key, i_wdata, i_dqm);
		if (i_cke) begin
			case ({i_cs_n, i_ras_n, i_cas_n, i_we_n})
				ACTIVATE: open_row[i_ba] <= i_addr;
				READ: begin
					read_key <= {i_ba, open_row[i_ba], i_addr[8:0]};
					read_beat_0 <= 1'b1;
				end
				WRITE: begin
					store({i_ba, open_row[i_ba], i_addr[8:0]}, i_wdata, i_dqm);
					write_key <= {i_ba, open_row[i_ba], i_addr[8:0]} + 24'd1;
					write_beat_1 <= 1'b1;
				end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/sdram_subsystem.sv
// SDRAM controller subsystem top level.
// Request queue, one open row tracker per bank and the command sequencer.

`timescale 1ns/10ps
`default_nettype none

module sdram_subsystem #(
	parameter int QUEUE_DEPTH = 4,
	parameter int STARTUP_CYCLES = 20000,
	parameter int MODE_WAIT = 2,
	parameter int REFRESH_INTERVAL = 500
)(
	input wire i_clock,
	input wire i_reset,
	input wire i_req,
	input wire i_rw,
	input wire [31:0] i_address,
	input wire [sdram_pkg::USER_DATA_WIDTH-1:0] i_wdata,
	input wire [3:0] i_wmask,
	output logic o_credit,
	output logic [sdram_pkg::USER_DATA_WIDTH-1:0] o_rdata,
	output logic o_rvalid,
	output logic o_sdram_cke,
	output logic o_sdram_cs_n,
	output logic o_sdram_ras_n,
	output logic o_sdram_cas_n,
	output logic o_sdram_we_n,
	output logic [1:0] o_sdram_dqm,
	output logic [1:0] o_sdram_ba,
	output logic [12:0] o_sdram_addr,
	output logic [sdram_pkg::SDRAM_DATA_WIDTH-1:0] o_sdram_wdata,
	output logic o_sdram_data_oe,
	input wire [sdram_pkg::SDRAM_DATA_WIDTH-1:0] i_sdram_rdata
);
	import sdram_pkg::*;

	logic head_valid;
	logic head_rw;
	logic [BANK_BITS-1:0] head_bank;
	logic [ROW_BITS-1:0] head_row;
	logic [COL_BITS-1:0] head_col;
	logic [USER_DATA_WIDTH-1:0] head_wdata;
	logic [3:0] head_wmask;
	logic head_pop;
	logic track_activate;
	logic [BANK_BITS-1:0] track_activate_bank;
	logic [ROW_BITS-1:0] track_activate_row;
	logic track_close_all;
	logic [NUM_BANKS-1:0] bank_hit;
	logic [NUM_BANKS-1:0] bank_open;

	sdram_request_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
		.i_clock(i_clock), .i_reset(i_reset),
		.i_req(i_req), .i_rw(i_rw), .i_address(i_address),
		.i_wdata(i_wdata), .i_wmask(i_wmask), .i_pop(head_pop),
		.o_credit(o_credit), .o_head_valid(head_valid), .o_head_rw(head_rw),
		.o_head_bank(head_bank), .o_head_row(head_row), .o_head_col(head_col),
		.o_head_wdata(head_wdata), .o_head_wmask(head_wmask)
	);

	for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
		sdram_bank_tracker #(.BANK_INDEX(b)) u_tracker (
			.i_clock(i_clock), .i_reset(i_reset),
			.i_head_bank(head_bank), .i_head_row(head_row),
			.i_activate(track_activate), .i_activate_bank(track_activate_bank),
			.i_activate_row(track_activate_row), .i_close_all(track_close_all),
			.o_row_hit(bank_hit[b]), .o_row_open(bank_open[b])
		);
	end

	sdram_command_sequencer #(
		.STARTUP_CYCLES(STARTUP_CYCLES),
		.MODE_WAIT(MODE_WAIT),
		.REFRESH_INTERVAL(REFRESH_INTERVAL)
	) u_sequencer (
		.i_clock(i_clock), .i_reset(i_reset),
		.i_head_valid(head_valid), .i_head_rw(head_rw), .i_head_bank(head_bank),
		.i_head_row(head_row), .i_head_col(head_col), .i_head_wdata(head_wdata),
		.i_head_wmask(head_wmask), .i_bank_hit(bank_hit), .i_bank_open(bank_open),
		.i_sdram_rdata(i_sdram_rdata),
		.o_head_pop(head_pop), .o_track_activate(track_activate),
		.o_track_activate_bank(track_activate_bank),
		.o_track_activate_row(track_activate_row),
		.o_track_close_all(track_close_all),
		.o_rdata(o_rdata), .o_rvalid(o_rvalid),
		.o_sdram_cke(o_sdram_cke), .o_sdram_cs_n(o_sdram_cs_n),
		.o_sdram_ras_n(o_sdram_ras_n), .o_sdram_cas_n(o_sdram_cas_n),
		.o_sdram_we_n(o_sdram_we_n), .o_sdram_dqm(o_sdram_dqm),
		.o_sdram_ba(o_sdram_ba), .o_sdram_addr(o_sdram_addr),
		.o_sdram_wdata(o_sdram_wdata), .o_sdram_data_oe(o_sdram_data_oe)
	);

endmodule

`default_nettype wire

//--- verilog/sdram_command_sequencer.sv
// SDRAM command sequencer.
// Power-up sequence, periodic refresh and row hit, empty and conflict
// access paths. Drives the chip pins and returns read words in order.

`timescale 1ns/10ps
`default_nettype none

module sdram_command_sequencer #(
	parameter int STARTUP_CYCLES = 20000,
	parameter int MODE_WAIT = 2,
	parameter int REFRESH_INTERVAL = 500
)(
	input wire i_clock,
	input wire i_reset,
	input wire i_head_valid,
	input wire i_head_rw,
	input wire [sdram_pkg::BANK_BITS-1:0] i_head_bank,
	input wire [sdram_pkg::ROW_BITS-1:0] i_head_row,
	input wire [sdram_pkg::COL_BITS-1:0] i_head_col,
	input wire [sdram_pkg::USER_DATA_WIDTH-1:0] i_head_wdata,
	input wire [3:0] i_head_wmask,
	input wire [sdram_pkg::NUM_BANKS-1:0] i_bank_hit,
	input wire [sdram_pkg::NUM_BANKS-1:0] i_bank_open,
	input wire [sdram_pkg::SDRAM_DATA_WIDTH-1:0] i_sdram_rdata,
	output logic o_head_pop,
	output logic o_track_activate,
	output logic [sdram_pkg::BANK_BITS-1:0] o_track_activate_bank,
	output logic [sdram_pkg::ROW_BITS-1:0] o_track_activate_row,
	output logic o_track_close_all,
	output logic [sdram_pkg::USER_DATA_WIDTH-1:0] o_rdata,
	output logic o_rvalid,
	output logic o_sdram_cke,
	output logic o_sdram_cs_n,
	output logic o_sdram_ras_n,
	output logic o_sdram_cas_n,
	output logic o_sdram_we_n,
	output logic [1:0] o_sdram_dqm,
	output logic [1:0] o_sdram_ba,
	output logic [12:0] o_sdram_addr,
	output logic [sdram_pkg::SDRAM_DATA_WIDTH-1:0] o_sdram_wdata,
	output logic o_sdram_data_oe
);
	import sdram_pkg::*;

	localparam int COUNT_BITS = 16;
	localparam int READ_TAP = CAS_LATENCY + 2;	// Second capture stage holds beat 0.
	localparam logic [12:0] ADDR_ALL_BANKS = 13'b0_0100_0000_0000;	// A10 high.

	seq_state_t state;
	command_t command;
	logic [COUNT_BITS-1:0] count;
	logic [COUNT_BITS-1:0] refresh_count;
	logic refresh_pending;
	logic any_open;

	// Request taken from the queue.
	logic req_rw;
	logic [BANK_BITS-1:0] req_bank;
	logic [ROW_BITS-1:0] req_row;
	logic [COL_BITS-1:0] req_col;
	logic [USER_DATA_WIDTH-1:0] req_wdata;
	logic [3:0] req_wmask;

	// Read capture.
	logic [READ_TAP:0] read_pipe;
	logic [SDRAM_DATA_WIDTH-1:0] capture_1;
	logic [SDRAM_DATA_WIDTH-1:0] capture_2;

	assign {o_sdram_cs_n, o_sdram_ras_n, o_sdram_cas_n, o_sdram_we_n} = command;
	assign o_track_activate_bank = req_bank;
	assign o_track_activate_row = req_row;

	// Free-running refresh timer.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			refresh_count <= '0;
		end else if (refresh_count == COUNT_BITS'(REFRESH_INTERVAL - 1)) begin
			refresh_count <= '0;
		end else begin
			refresh_count <= refresh_count + 1'b1;
		end
	end

	// ============================================================
	// Main state machine.
	// ============================================================
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= ST_STARTUP;
			command <= CMD_NOP;
			count <= COUNT_BITS'(STARTUP_CYCLES - 1);
			refresh_pending <= 1'b0;
			any_open <= 1'b0;
			o_sdram_cke <= 1'b0;
			o_sdram_dqm <= 2'b11;
			o_sdram_data_oe <= 1'b0;
			o_head_pop <= 1'b0;
			o_track_activate <= 1'b0;
			o_track_close_all <= 1'b0;
		end else begin
			command <= CMD_NOP;
			count <= count - 1'b1;
			o_head_pop <= 1'b0;
			o_track_activate <= 1'b0;
			o_track_close_all <= 1'b0;
			o_sdram_data_oe <= 1'b0;
			if (o_sdram_cke)
				o_sdram_dqm <= 2'b00;

			if (o_track_activate)
				any_open <= 1'b1;

			case (state)
				ST_STARTUP: begin
					if (count <= COUNT_BITS'((STARTUP_CYCLES * 3) / 4)) begin
						o_sdram_cke <= 1'b1;
						o_sdram_dqm <= 2'b00;
					end
					if (count == 0)
						state <= ST_STARTUP_PRECHARGE;
				end
				ST_STARTUP_PRECHARGE: begin
					command <= CMD_PRECHARGE;
					o_sdram_ba <= 2'b00;
					o_sdram_addr <= ADDR_ALL_BANKS;
					count <= COUNT_BITS'(T_RP - 1);
					state <= ST_STARTUP_WAIT_PRECHARGE;
				end
				ST_STARTUP_WAIT_PRECHARGE: begin
					if (count == 0)
						state <= ST_STARTUP_REFRESH_1;
				end
				ST_STARTUP_REFRESH_1: begin
					command <= CMD_REFRESH;
					state <= ST_STARTUP_REFRESH_2;
				end
				ST_STARTUP_REFRESH_2: begin
					command <= CMD_REFRESH;
					count <= COUNT_BITS'(T_RFC - 1);
					state <= ST_STARTUP_WAIT_REFRESH;
				end
				ST_STARTUP_WAIT_REFRESH: begin
					if (count == 0)
						state <= ST_SET_MODE;
				end
				ST_SET_MODE: begin
					command <= CMD_SET_MODE;
					o_sdram_ba <= 2'b00;
					o_sdram_addr <= MODE_WORD;
					count <= COUNT_BITS'(MODE_WAIT - 1);
					state <= ST_WAIT_SET_MODE;
				end
				ST_WAIT_SET_MODE: begin
					if (count == 0)
						state <= ST_IDLE;
				end

				ST_IDLE: begin
					if (refresh_pending) begin
						refresh_pending <= 1'b0;
						if (any_open) begin	// Rows must be closed before refresh.
							command <= CMD_PRECHARGE;
							o_sdram_addr <= ADDR_ALL_BANKS;
							o_track_close_all <= 1'b1;
							any_open <= 1'b0;
							count <= COUNT_BITS'(T_RP - 1);
							state <= ST_WAIT_PRECHARGE_ALL;
						end else begin
							state <= ST_REFRESH;
						end
					end else if (i_head_valid) begin
						o_head_pop <= 1'b1;
						req_rw <= i_head_rw;
						req_bank <= i_head_bank;
						req_row <= i_head_row;
						req_col <= i_head_col;
						req_wdata <= i_head_wdata;
						req_wmask <= i_head_wmask;
						o_sdram_ba <= i_head_bank;
						if (|i_bank_hit) begin
							state <= ST_ACCESS;
						end else if (|i_bank_open) begin
							command <= CMD_PRECHARGE;	// Close the other row.
							o_sdram_addr <= '0;
							count <= COUNT_BITS'(T_RP);	// Wait state issues the activate.
							state <= ST_WAIT_PRECHARGE;
						end else begin
							command <= CMD_ACTIVATE;
							o_sdram_addr <= i_head_row;
							o_track_activate <= 1'b1;
							count <= COUNT_BITS'(T_RCD - 1);
							state <= ST_WAIT_ACTIVATE;
						end
					end
				end
				ST_WAIT_PRECHARGE_ALL: begin
					if (count == 0)
						state <= ST_REFRESH;
				end
				ST_REFRESH: begin
					command <= CMD_REFRESH;
					count <= COUNT_BITS'(T_RFC - 1);
					state <= ST_WAIT_REFRESH;
				end
				ST_WAIT_REFRESH: begin
					if (count == 0)
						state <= ST_IDLE;
				end
				ST_WAIT_PRECHARGE: begin
					if (count == 0) begin
						command <= CMD_ACTIVATE;
						o_sdram_addr <= req_row;
						o_track_activate <= 1'b1;
						count <= COUNT_BITS'(T_RCD - 1);
						state <= ST_WAIT_ACTIVATE;
					end
				end
				ST_WAIT_ACTIVATE: begin
					if (count == 0)
						state <= ST_ACCESS;
				end
				ST_ACCESS: begin
					command <= req_rw ? CMD_WRITE : CMD_READ;
					o_sdram_ba <= req_bank;
					o_sdram_addr <= {4'b0000, req_col, 1'b0};	// A10 low, no auto precharge.
					if (req_rw) begin
						o_sdram_wdata <= req_wdata[15:0];
						o_sdram_dqm <= ~req_wmask[1:0];
						o_sdram_data_oe <= 1'b1;
						state <= ST_WAIT_WRITE;
					end else begin
						count <= COUNT_BITS'(CAS_LATENCY);
						state <= ST_WAIT_READ;
					end
				end
				ST_WAIT_WRITE: begin
					o_sdram_wdata <= req_wdata[31:16];	// Second beat.
					o_sdram_dqm <= ~req_wmask[3:2];
					o_sdram_data_oe <= 1'b1;
					state <= ST_IDLE;
				end
				ST_WAIT_READ: begin
					if (count == 0)
						state <= ST_IDLE;	// Last beat is on the bus now.
				end
				default: begin
					state <= ST_STARTUP;
				end
			endcase

			// Set wins over the clear in idle.
			if (refresh_count == COUNT_BITS'(REFRESH_INTERVAL - 1))
				refresh_pending <= 1'b1;
		end
	end

	// ============================================================
	// Read capture and return.
	// ============================================================
	always_ff @(posedge i_clock) begin
		capture_1 <= i_sdram_rdata;
		capture_2 <= capture_1;
		if (read_pipe[READ_TAP])
			o_rdata <= {capture_1, capture_2};	// Beat 1 is high half.
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			read_pipe <= '0;
			o_rvalid <= 1'b0;
		end else begin
			read_pipe <= {read_pipe[READ_TAP-1:0], state == ST_ACCESS && !req_rw};
			o_rvalid <= read_pipe[READ_TAP];
		end
	end

	a_no_access_without_cke: assert property (@(posedge i_clock) disable iff (i_reset)
		(command == CMD_READ || command == CMD_WRITE) |-> o_sdram_cke);

endmodule

`default_nettype wire

//--- verilog/sdram_bank_tracker.sv
// Open row tracker for one SDRAM bank.
// Flags whether the head request hits the open row or finds another open.

`timescale 1ns/10ps
`default_nettype none

module sdram_bank_tracker #(
	parameter int BANK_INDEX = 0
)(
	input wire i_clock,
	input wire i_reset,
	input wire [sdram_pkg::BANK_BITS-1:0] i_head_bank,
	input wire [sdram_pkg::ROW_BITS-1:0] i_head_row,
	input wire i_activate,
	input wire [sdram_pkg::BANK_BITS-1:0] i_activate_bank,
	input wire [sdram_pkg::ROW_BITS-1:0] i_activate_row,
	input wire i_close_all,
	output logic o_row_hit,
	output logic o_row_open
);
	import sdram_pkg::*;

	logic is_open;
	logic [ROW_BITS-1:0] open_row;
	logic my_head;
	logic my_activate;

	assign my_head = (i_head_bank == BANK_BITS'(BANK_INDEX));
	assign my_activate = i_activate && (i_activate_bank == BANK_BITS'(BANK_INDEX));

	assign o_row_open = my_head && is_open;
	assign o_row_hit = o_row_open && (open_row == i_head_row);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			is_open <= 1'b0;
		end else if (i_close_all) begin
			is_open <= 1'b0;
		end else if (my_activate) begin
			is_open <= 1'b1;
		end
	end

	always_ff @(posedge i_clock) begin
		if (my_activate)
			open_row <= i_activate_row;	// Payload only.
	end

	// A hit must never be served by a fresh activate of the same row.
	a_no_redundant_activate: assert property (@(posedge i_clock) disable iff (i_reset)
		my_activate |-> !(is_open && open_row == i_activate_row));

endmodule

`default_nettype wire

//--- verilog/sdram_request_queue.sv
// Host request queue.
// Circular buffer of word-aligned requests, split into bank, row and
// column on entry. One credit goes back to the host per pop.

`timescale 1ns/10ps
`default_nettype none

module sdram_request_queue #(
	parameter int QUEUE_DEPTH = 4
)(
	input wire i_clock,
	input wire i_reset,
	input wire i_req,
	input wire i_rw,
	input wire [31:0] i_address,
	input wire [sdram_pkg::USER_DATA_WIDTH-1:0] i_wdata,
	input wire [3:0] i_wmask,
	input wire i_pop,
	output logic o_credit,
	output logic o_head_valid,
	output logic o_head_rw,
	output logic [sdram_pkg::BANK_BITS-1:0] o_head_bank,
	output logic [sdram_pkg::ROW_BITS-1:0] o_head_row,
	output logic [sdram_pkg::COL_BITS-1:0] o_head_col,
	output logic [sdram_pkg::USER_DATA_WIDTH-1:0] o_head_wdata,
	output logic [3:0] o_head_wmask
);
	import sdram_pkg::*;

	localparam int PTR_BITS = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam logic [PTR_BITS-1:0] LAST = PTR_BITS'(QUEUE_DEPTH - 1);

	logic rw_mem [QUEUE_DEPTH];
	logic [BANK_BITS-1:0] bank_mem [QUEUE_DEPTH];
	logic [ROW_BITS-1:0] row_mem [QUEUE_DEPTH];
	logic [COL_BITS-1:0] col_mem [QUEUE_DEPTH];
	logic [USER_DATA_WIDTH-1:0] wdata_mem [QUEUE_DEPTH];
	logic [3:0] wmask_mem [QUEUE_DEPTH];

	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [PTR_BITS:0] count;
	logic do_pop;

	assign o_head_valid = (count != 0);
	assign do_pop = i_pop && o_head_valid;
	assign o_credit = do_pop;	// Credit goes back in the pop cycle.

	assign o_head_rw = rw_mem[rd_ptr];
	assign o_head_bank = bank_mem[rd_ptr];
	assign o_head_row = row_mem[rd_ptr];
	assign o_head_col = col_mem[rd_ptr];
	assign o_head_wdata = wdata_mem[rd_ptr];
	assign o_head_wmask = wmask_mem[rd_ptr];

	// Word address is row, bank, column from the top.
	always_ff @(posedge i_clock) begin
		if (i_req) begin
			rw_mem[wr_ptr] <= i_rw;
			col_mem[wr_ptr] <= i_address[9:2];
			bank_mem[wr_ptr] <= i_address[11:10];
			row_mem[wr_ptr] <= i_address[24:12];
			wdata_mem[wr_ptr] <= i_wdata;
			wmask_mem[wr_ptr] <= i_wmask;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (i_req)
				wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
			count <= count + (i_req ? 1'b1 : 1'b0) - (do_pop ? 1'b1 : 1'b0);
		end
	end

	// The host must hold a credit for every request.
	a_no_push_when_full: assert property (@(posedge i_clock) disable iff (i_reset)
		i_req |-> (count < QUEUE_DEPTH || do_pop));

	a_no_pop_when_empty: assert property (@(posedge i_clock) disable iff (i_reset)
		i_pop |-> o_head_valid);

endmodule

`default_nettype wire

//--- verilog/sdram_pkg.sv
// SDRAM controller shared definitions.
// Command encodings, sequencer states, address fields and chip timing
// for a 16-bit SDR SDRAM with 4 banks.

`default_nettype none

package sdram_pkg;

	// Word address fields. Byte address bits 1:0 are dropped.
	localparam int BANK_BITS = 2;
	localparam int ROW_BITS = 13;
	localparam int COL_BITS = 8;
	localparam int NUM_BANKS = 4;

	localparam int USER_DATA_WIDTH = 32;
	localparam int SDRAM_DATA_WIDTH = 16;
	localparam int BURST_COUNT = USER_DATA_WIDTH / SDRAM_DATA_WIDTH;
	localparam int CAS_LATENCY = 2;

	// Chip timing in cycles.
	localparam int T_RP = 1;
	localparam int T_RFC = 7;
	localparam int T_RCD = 1;

	// Mode register fields.
	localparam logic [2:0] MODE_BURST_2 = 3'b001;
	localparam logic MODE_SEQUENTIAL = 1'b0;
	localparam logic [2:0] MODE_CAS_2 = 3'b010;
	localparam logic MODE_WRITE_BURST = 1'b0;	// Programmed burst writes.

	localparam logic [12:0] MODE_WORD = {3'b000, MODE_WRITE_BURST, 2'b00,
		MODE_CAS_2, MODE_SEQUENTIAL, MODE_BURST_2};

	// Bits are cs_n, ras_n, cas_n, we_n.
	typedef enum logic [3:0] {
		CMD_NOP       = 4'b0111,
		CMD_PRECHARGE = 4'b0010,
		CMD_SET_MODE  = 4'b0000,
		CMD_REFRESH   = 4'b0001,
		CMD_ACTIVATE  = 4'b0011,
		CMD_READ      = 4'b0101,
		CMD_WRITE     = 4'b0100
	} command_t;

	typedef enum logic [4:0] {
		ST_STARTUP,
		ST_STARTUP_PRECHARGE,
		ST_STARTUP_WAIT_PRECHARGE,
		ST_STARTUP_REFRESH_1,
		ST_STARTUP_REFRESH_2,
		ST_STARTUP_WAIT_REFRESH,
		ST_SET_MODE,
		ST_WAIT_SET_MODE,
		ST_IDLE,
		ST_REFRESH,
		ST_WAIT_REFRESH,
		ST_WAIT_PRECHARGE_ALL,
		ST_WAIT_PRECHARGE,
		ST_WAIT_ACTIVATE,
		ST_ACCESS,
		ST_WAIT_READ,
		ST_WAIT_WRITE
	} seq_state_t;

endpackage

`default_nettype wire
